// ==== aggr_stage.sv ====
`timescale 1ns/100ps
`include "gat_params.svh"

module aggr_stage
  import gat_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  stream_if.sink in,
  output logic   node_vld_o,
  input  logic   node_rdy_i,
  output sum_t   node_o
);

  localparam int CW = $clog2(`GAT_AGGR_LEN);

  logic          take;
  logic          grp_last;
  logic [CW-1:0] cnt_q;
  sum_t          acc_q;
  sum_t          node_q;
  logic          vld_q;

  assign in.ready = ~vld_q | node_rdy_i;
  assign take     = in.valid & in.ready;
  assign grp_last = cnt_q == CW'(`GAT_AGGR_LEN - 1);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
      acc_q <= '0;
      vld_q <= 1'b0;
    end else begin
      if (vld_q && node_rdy_i)
        vld_q <= 1'b0;
      if (take) begin
        if (grp_last) begin
          cnt_q <= '0;
          acc_q <= '0; // next group starts from zero
          vld_q <= 1'b1;
        end else begin
          cnt_q <= cnt_q + 1'b1;
          acc_q <= acc_q + in.sum;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take && grp_last)
      node_q <= acc_q + in.sum;
  end

  assign node_vld_o = vld_q;
  assign node_o     = node_q;

endmodule

// ==== debug_monitor.sv ====
`timescale 1ns/100ps
`include "gat_params.svh"

module debug_monitor
  import gat_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        in_vld_i,
  input  logic        in_rdy_i,
  stream_if.monitor   s1_mon,
  stream_if.monitor   s2_mon,
  stream_if.monitor   s3_mon,
  input  logic        feat_oob_i,
  output logic [31:0] debug_cnt_o,
  output logic [31:0] debug_flags_o,
  output logic [31:0] debug_cap_o
);

  logic [8:0]  seen;
  logic [8:0]  flags_q;
  logic [31:0] cnt_q;
  sum_t        cap_q;
  logic        s1_xfer;
  logic        s3_xfer;

  // one bit per handshake line, input side first
  assign seen = {
    feat_oob_i,
    s3_mon.ready,
    s3_mon.valid,
    s2_mon.ready,
    s2_mon.valid,
    s1_mon.ready,
    s1_mon.valid,
    in_rdy_i,
    in_vld_i
  };

  assign s1_xfer = s1_mon.valid & s1_mon.ready;
  assign s3_xfer = s3_mon.valid & s3_mon.ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flags_q <= '0;
      cnt_q   <= '0;
      cap_q   <= '0;
    end else begin
      flags_q <= flags_q | seen; // sticky until reset
      if (s3_xfer)
        cnt_q <= cnt_q + 1'b1;
      if (s1_xfer && s1_mon.row == row_t'(`GAT_DBG_ROW))
        cap_q <= s1_mon.sum;
    end
  end

  assign debug_flags_o = {23'b0, flags_q};
  assign debug_cnt_o   = cnt_q;
  assign debug_cap_o   = cap_q;

endmodule

// ==== dmvm_stage.sv ====
`timescale 1ns/100ps
`include "gat_params.svh"

module dmvm_stage
  import gat_pkg::*;
(
  input  logic               clk,
  input  logic               rst_n,
  stream_if.sink             in,
  stream_if.source           out,
  input  logic               wgt_we_i,
  input  logic [1:0]         wgt_addr_i,
  input  logic signed [15:0] wgt_data_i
);

  localparam int WA_W = $clog2(`GAT_NUM_WGT);

  logic signed [15:0] wgt_mem [`GAT_NUM_WGT];

  logic               take;
  logic signed [47:0] prod;
  logic               vld_q;
  sum_t               sum_q;
  row_t               row_q;

  // weights are written from the host side on the strobe edge
  always_ff @(posedge clk) begin
    if (wgt_we_i)
      wgt_mem[wgt_addr_i] <= wgt_data_i;
  end

  assign in.ready = ~vld_q | out.ready;
  assign take     = in.valid & in.ready;

  assign prod = in.sum * wgt_mem[in.row[WA_W-1:0]]; // low row bits pick the weight

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_q <= 1'b0;
    end else begin
      if (take)
        vld_q <= 1'b1;
      else if (out.ready)
        vld_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      sum_q <= sum_t'(prod >>> `GAT_WGT_SHIFT); // keep the low 32 bits of the scaled product
      row_q <= in.row;
    end
  end

  assign out.valid = vld_q;
  assign out.sum   = sum_q;
  assign out.row   = row_q;

endmodule

// ==== gat_params.svh ====
`ifndef GAT_PARAMS_SVH
`define GAT_PARAMS_SVH

// feature table entries, addressed by the nonzero column
`define GAT_FEAT_DEPTH 64

// weight table entries, a row picks row id modulo this
`define GAT_NUM_WGT 4

// rows summed into one node result
`define GAT_AGGR_LEN 4

// fixed-point scaling after the weight multiply
`define GAT_WGT_SHIFT 8

// leak factor for negative scores is 2**-GAT_LEAK_SHIFT
`define GAT_LEAK_SHIFT 3

`define GAT_DBG_ROW 5 // row whose sparse sum the monitor keeps

`define GAT_ROW_W 8

`endif

// ==== gat_pkg.sv ====
`include "gat_params.svh"

package gat_pkg;

  typedef logic [`GAT_ROW_W-1:0] row_t;

  typedef logic signed [31:0] sum_t;

  // sparse nonzero element, kind is 0
  typedef struct packed {
    logic               kind;
    logic               last;  // closes the current row
    logic [5:0]         col;
    logic [7:0]         pad;
    logic signed [15:0] val;
  } nz_t;

  // feature table write, kind is 1
  typedef struct packed {
    logic               kind;
    logic [6:0]         addr;  // the top bit lands outside the table
    logic [7:0]         pad;
    logic signed [15:0] data;
  } fw_t;

  // the kind bit sits at bit 31 in both views and selects the decoding
  typedef union packed {
    nz_t nz;
    fw_t fw;
  } in_word_u;

endpackage

// ==== gat_testdata.txt ====
# W addr data | I word | E node | F flags cnt cap, all values in hex
# I words are fed in order, E values are the node results in order
W 0 0100
W 1 0200
W 2 0080
W 3 ff00
# feature table entries 0 to 4
I 8000000a
I 81000003
I 8200fffc
I 83000007
I 84000064
# group of rows 0 to 3
I 00000002
I 41000005
I 42000003
I 43000004
I 4100fffe
# group of rows 4 to 7, row 5 is captured
I 44000001
I 00000003
I 42000005
I 4200000a
I 03000001
I 44000002
# write outside the table, then rows 8 to 11 all use entry 0
I c0007fff
I 4000fffb
I 0000ffff
I 4100fffe
I 4000fff8
I 40000004
E 00000034
E 0000005b
E ffffffeb
F 000001ff 0000000c 0000000a

// ==== gat_top.sv ====
`timescale 1ns/100ps

module gat_top (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               in_vld_i,
  output logic               in_rdy_o,
  input  logic [31:0]        in_word_i,
  output logic               node_vld_o,
  input  logic               node_rdy_i,
  output logic [31:0]        node_o,
  input  logic               wgt_we_i,
  input  logic [1:0]         wgt_addr_i,
  input  logic signed [15:0] wgt_data_i,
  output logic [31:0]        debug_cnt_o,
  output logic [31:0]        debug_flags_o,
  output logic [31:0]        debug_cap_o
);

  logic feat_oob;

  stream_if s1 ();
  stream_if s2 ();
  stream_if s3 ();

  spmm_stage u_spmm (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_vld_i   (in_vld_i),
    .in_word_i  (in_word_i),
    .in_rdy_o   (in_rdy_o),
    .out        (s1.source),
    .feat_oob_o (feat_oob)
  );

  dmvm_stage u_dmvm (
    .clk        (clk),
    .rst_n      (rst_n),
    .in         (s1.sink),
    .out        (s2.source),
    .wgt_we_i   (wgt_we_i),
    .wgt_addr_i (wgt_addr_i),
    .wgt_data_i (wgt_data_i)
  );

  score_stage u_score (
    .clk   (clk),
    .rst_n (rst_n),
    .in    (s2.sink),
    .out   (s3.source)
  );

  aggr_stage u_aggr (
    .clk        (clk),
    .rst_n      (rst_n),
    .in         (s3.sink),
    .node_vld_o (node_vld_o),
    .node_rdy_i (node_rdy_i),
    .node_o     (node_o)
  );

  // observes only, drives nothing back into the pipeline
  debug_monitor u_dbg (
    .clk           (clk),
    .rst_n         (rst_n),
    .in_vld_i      (in_vld_i),
    .in_rdy_i      (in_rdy_o),
    .s1_mon        (s1.monitor),
    .s2_mon        (s2.monitor),
    .s3_mon        (s3.monitor),
    .feat_oob_i    (feat_oob),
    .debug_cnt_o   (debug_cnt_o),
    .debug_flags_o (debug_flags_o),
    .debug_cap_o   (debug_cap_o)
  );

endmodule

// ==== score_stage.sv ====
`timescale 1ns/100ps
`include "gat_params.svh"

module score_stage
  import gat_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  stream_if.sink   in,
  stream_if.source out
);

  logic take;
  sum_t leaked;
  logic vld_q;
  sum_t sum_q;
  row_t row_q;

  assign in.ready = ~vld_q | out.ready;
  assign take     = in.valid & in.ready;

  // leaky activation, negative scores shrink by a power of two
  assign leaked = in.sum[31] ? (in.sum >>> `GAT_LEAK_SHIFT) : in.sum;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_q <= 1'b0;
    end else begin
      if (take)
        vld_q <= 1'b1;
      else if (out.ready)
        vld_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      sum_q <= leaked;
      row_q <= in.row;
    end
  end

  assign out.valid = vld_q;
  assign out.sum   = sum_q;
  assign out.row   = row_q;

endmodule

// ==== sources.f ====
+incdir+.
gat_pkg.sv
stream_if.sv
spmm_stage.sv
dmvm_stage.sv
score_stage.sv
aggr_stage.sv
debug_monitor.sv
gat_top.sv
tb_gat_top.sv

// ==== spmm_stage.sv ====
`timescale 1ns/100ps
`include "gat_params.svh"

module spmm_stage
  import gat_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     in_vld_i,
  input  in_word_u in_word_i,
  output logic     in_rdy_o,
  stream_if.source out,
  output logic     feat_oob_o
);

  localparam int FA_W = $clog2(`GAT_FEAT_DEPTH);

  logic signed [15:0] feat_mem [`GAT_FEAT_DEPTH];

  logic               is_fw;
  logic               accept;
  logic               nz_take;
  logic               fw_in_range;
  logic               row_done;
  logic signed [31:0] prod;
  sum_t               acc_q;
  sum_t               sum_q;
  row_t               row_cnt_q;
  logic               vld_q;

  assign is_fw    = in_word_i.fw.kind;
  assign in_rdy_o = is_fw | ~vld_q; // a nonzero waits while the output register is full
  assign accept   = in_vld_i & in_rdy_o;
  assign nz_take  = accept & ~is_fw;
  assign row_done = nz_take & in_word_i.nz.last;

  assign fw_in_range = in_word_i.fw.addr < `GAT_FEAT_DEPTH;
  assign feat_oob_o  = accept & is_fw & ~fw_in_range;

  assign prod = in_word_i.nz.val * feat_mem[in_word_i.nz.col];

  always_ff @(posedge clk) begin
    if (accept && is_fw && fw_in_range)
      feat_mem[in_word_i.fw.addr[FA_W-1:0]] <= in_word_i.fw.data;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_q     <= '0;
      vld_q     <= 1'b0;
      row_cnt_q <= '0;
    end else begin
      if (vld_q && out.ready) begin
        vld_q     <= 1'b0;
        row_cnt_q <= row_cnt_q + 1'b1; // next row gets the next id
      end
      if (row_done) begin
        acc_q <= '0;
        vld_q <= 1'b1;
      end else if (nz_take) begin
        acc_q <= acc_q + prod;
      end
    end
  end

  // the closing element's product goes straight into the emitted sum
  always_ff @(posedge clk) begin
    if (row_done)
      sum_q <= acc_q + prod;
  end

  assign out.valid = vld_q;
  assign out.sum   = sum_q;
  assign out.row   = row_cnt_q;

endmodule

// ==== stream_if.sv ====
`timescale 1ns/100ps

interface stream_if
  import gat_pkg::*;
();

  logic valid;
  logic ready;
  sum_t sum;
  row_t row;

  // source holds valid, sum and row until the cycle where ready is also high
  modport source (
    output valid,
    output sum,
    output row,
    input  ready
  );

  modport sink (
    input  valid,
    input  sum,
    input  row,
    output ready
  );

  modport monitor (input valid, input ready, input sum, input row);

endinterface

// ==== tb_gat_top.sv ====
`timescale 1ns/100ps

module tb_gat_top
  import gat_pkg::*;
();

  localparam int TIMEOUT = 2000;

  logic               clk;
  logic               rst_n;
  logic               in_vld_i;
  logic               in_rdy_o;
  logic [31:0]        in_word_i;
  logic               node_vld_o;
  logic               node_rdy_i;
  logic [31:0]        node_o;
  logic               wgt_we_i;
  logic [1:0]         wgt_addr_i;
  logic signed [15:0] wgt_data_i;
  logic [31:0]        debug_cnt_o;
  logic [31:0]        debug_flags_o;
  logic [31:0]        debug_cap_o;

  integer      seed = 32'h626f_f4ec;
  logic [31:0] bp_rnd;

  logic [31:0] word_q [$];
  sum_t        exp_q [$];
  logic [1:0]  wa_q [$];
  logic [15:0] wd_q [$];
  logic [31:0] exp_flags;
  logic [31:0] exp_cnt;
  logic [31:0] exp_cap;
  bit          have_final;

  int err_cnt;
  int test_cnt;
  int test_err0;
  int n_exp;
  int nodes_seen;
  int extra;

  gat_top DUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .in_vld_i      (in_vld_i),
    .in_rdy_o      (in_rdy_o),
    .in_word_i     (in_word_i),
    .node_vld_o    (node_vld_o),
    .node_rdy_i    (node_rdy_i),
    .node_o        (node_o),
    .wgt_we_i      (wgt_we_i),
    .wgt_addr_i    (wgt_addr_i),
    .wgt_data_i    (wgt_data_i),
    .debug_cnt_o   (debug_cnt_o),
    .debug_flags_o (debug_flags_o),
    .debug_cap_o   (debug_cap_o)
  );

  always #2 clk = ~clk;

  // downstream ready toggles at random every cycle
  always @(posedge clk) begin
    bp_rnd = $random(seed);
    node_rdy_i <= bp_rnd[0];
  end

  task automatic check_word32(input string name, input logic [31:0] got,
                              input logic [31:0] exp_val);
    if (got !== exp_val) begin
      $display("Mismatch %0s: got %h, expected %h", name, got, exp_val);
      err_cnt++;
    end
  endtask

  task automatic check_node(input int idx, input sum_t got, input sum_t exp_val);
    if (got !== exp_val) begin
      $display("Mismatch node_o[%0d]: got %h, expected %h", idx, got, exp_val);
      err_cnt++;
    end
  endtask

  task automatic check_flags(input logic [31:0] got, input logic [31:0] exp_val);
    if (got !== exp_val) begin
      $display("Mismatch debug_flags_o: got %h, expected %h, differing bits %h",
               got, exp_val, got ^ exp_val);
      err_cnt++;
    end
  endtask

  task automatic read_testdata();
    integer            fd;
    integer            n;
    logic [8*8-1:0]    tok;
    logic [8*128-1:0]  rest;
    logic [31:0]       a;
    logic [31:0]       b;
    logic [31:0]       c;
    bit                done;
    fd = $fopen("gat_testdata.txt", "r");
    if (fd == 0) begin
      $display("could not open gat_testdata.txt");
      err_cnt++;
    end else begin
      done = 0;
      while (!done) begin
        n = $fscanf(fd, "%s", tok);
        if (n != 1) begin
          done = 1;
        end else if (tok == "#") begin
          n = $fgets(rest, fd);
        end else if (tok == "W") begin
          n = $fscanf(fd, "%h %h", a, b);
          wa_q.push_back(a[1:0]);
          wd_q.push_back(b[15:0]);
        end else if (tok == "I") begin
          n = $fscanf(fd, "%h", a);
          word_q.push_back(a);
        end else if (tok == "E") begin
          n = $fscanf(fd, "%h", a);
          exp_q.push_back(sum_t'(a));
        end else if (tok == "F") begin
          n = $fscanf(fd, "%h %h %h", a, b, c);
          exp_flags  = a;
          exp_cnt    = b;
          exp_cap    = c;
          have_final = (n == 3);
        end else begin
          $display("unknown command %0s in gat_testdata.txt", tok);
          err_cnt++;
          done = 1;
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic write_weight(input logic [1:0] addr, input logic [15:0] data);
    @(posedge clk);
    wgt_we_i   <= 1'b1;
    wgt_addr_i <= addr;
    wgt_data_i <= data;
    @(posedge clk);
    wgt_we_i   <= 1'b0; // the write lands on this edge
  endtask

  task automatic send_words();
    int          waited;
    int          sent;
    logic [31:0] w;
    bit          aborted;
    sent    = 0;
    aborted = 0;
    while (word_q.size() > 0 && !aborted) begin
      w = word_q.pop_front();
      @(posedge clk);
      in_vld_i  <= 1'b1;
      in_word_i <= w;
      waited    = 0;
      @(negedge clk);
      while (!in_rdy_o && waited < TIMEOUT) begin
        @(negedge clk);
        waited++;
      end
      if (in_rdy_o) begin
        sent++; // accepted on the coming edge
      end else begin
        $display("timeout waiting for in_rdy_o on input word %0d", sent);
        err_cnt++;
        aborted = 1;
      end
    end
    @(posedge clk);
    in_vld_i <= 1'b0;
  endtask

  task automatic collect_nodes();
    int  idle;
    int  idx;
    bit  aborted;
    idx     = 0;
    aborted = 0;
    while (idx < n_exp && !aborted) begin
      idle = 0;
      @(negedge clk);
      while (!(node_vld_o && node_rdy_i) && idle < TIMEOUT) begin
        @(negedge clk);
        idle++;
      end
      if (node_vld_o && node_rdy_i) begin
        check_node(idx, sum_t'(node_o), exp_q[idx]);
        idx++;
      end else begin
        $display("timeout waiting for node result %0d", idx);
        err_cnt++;
        aborted = 1;
      end
    end
    nodes_seen = idx;
  endtask

  task automatic report_test(input string name);
    test_cnt++;
    if (err_cnt == test_err0)
      $display("test %0d %0s: ok", test_cnt, name);
    else
      $display("test %0d %0s: %0d error(s)", test_cnt, name, err_cnt - test_err0);
  endtask

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    in_vld_i   = 1'b0;
    in_word_i  = '0;
    node_rdy_i = 1'b0;
    wgt_we_i   = 1'b0;
    wgt_addr_i = '0;
    wgt_data_i = '0;
    err_cnt    = 0;
    test_cnt   = 0;
    have_final = 0;
    nodes_seen = 0;
    extra      = 0;

    read_testdata();
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    // sticky flags pick up the ready lines on the first edge after release
    test_err0 = err_cnt;
    @(negedge clk);
    check_word32("in_rdy_o", {31'b0, in_rdy_o}, 32'd1);
    check_word32("node_vld_o", {31'b0, node_vld_o}, 32'd0);
    check_word32("debug_cnt_o", debug_cnt_o, 32'd0);
    check_word32("debug_cap_o", debug_cap_o, 32'd0);
    check_flags(debug_flags_o, 32'd0);
    report_test("reset_state");

    while (wa_q.size() > 0)
      write_weight(wa_q.pop_front(), wd_q.pop_front());

    test_err0 = err_cnt;
    n_exp     = exp_q.size();
    fork
      send_words();
      collect_nodes();
    join
    if (nodes_seen == n_exp) begin
      repeat (20) begin
        @(negedge clk);
        if (node_vld_o)
          extra++;
      end
      if (extra != 0) begin
        $display("node_vld_o was high %0d time(s) after the last expected node", extra);
        err_cnt++;
      end
    end
    report_test($sformatf("node_stream %0d of %0d nodes", nodes_seen, n_exp));

    test_err0 = err_cnt;
    @(negedge clk);
    if (!have_final) begin
      $display("gat_testdata.txt has no complete F line");
      err_cnt++;
    end else begin
      check_word32("debug_cnt_o", debug_cnt_o, exp_cnt);
      check_word32("debug_cap_o", debug_cap_o, exp_cap);
    end
    report_test("debug_counters");

    test_err0 = err_cnt;
    if (have_final)
      check_flags(debug_flags_o, exp_flags);
    report_test("debug_flags");

    $display("%0d tests run, %0d errors", test_cnt, err_cnt);
    if (err_cnt == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule
